// File: src/rc_link_pkg.sv
//====================
// Shared types, frame layout, defaults and timing limits for the RC link
// CLKS_PER_BIT is kept tiny to keep simulation short, scale it for real baud
// Timeouts are in clk cycles
//====================

package rc_link_pkg;

	// Raw field byte from the frame
	typedef logic [7:0] rc_byte_t;

	// Mixed, saturated setpoint
	typedef logic signed [7:0] setpoint_t;

	// Wide enough for (stick - center) + (trim - center)
	typedef logic signed [9:0] mix_sum_t;

	// Frame layout
	localparam rc_byte_t SYNC1 = 8'hFF;
	localparam rc_byte_t SYNC2 = 8'h5A;
	localparam int FRAME_RESERVED_BYTES = 5;
	localparam int RSV_CNT_W = $clog2(FRAME_RESERVED_BYTES);
	localparam rc_byte_t STICK_CENTER = 8'd128;

	// Altitude commands below this decode as zero
	localparam rc_byte_t ALT_DEAD_ZONE = 8'd10;

	// Values after reset and on link loss
	localparam rc_byte_t DEFAULT_ALT = 8'd0;
	localparam rc_byte_t DEFAULT_STICK = 8'd128;
	localparam rc_byte_t DEFAULT_KP = 8'd16;
	localparam rc_byte_t DEFAULT_KI = 8'd0;
	localparam rc_byte_t DEFAULT_OFFSET = 8'd128;

	// Setpoint clamp limits
	localparam setpoint_t SP_MAX = 8'sd127;
	localparam setpoint_t SP_MIN = -8'sd128;

	// UART bit timing, simulation sized
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

	// Inter-byte gap that abandons a partial frame
	localparam int GAP_TIMEOUT = 400;
	localparam int GAP_CNT_W = $clog2(GAP_TIMEOUT + 1);

	// Frame silence before failsafe
	localparam int LINK_TIMEOUT = 6000;
	localparam int LINK_CNT_W = $clog2(LINK_TIMEOUT + 1);

	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	typedef logic [GAP_CNT_W-1:0] gap_cnt_t;
	typedef logic [LINK_CNT_W-1:0] link_cnt_t;
	typedef logic [RSV_CNT_W-1:0] rsv_cnt_t;

endpackage

// File: src/uart_byte_rx.sv
//====================
// 8N1 receiver, LSB first, CLKS_PER_BIT clocks per bit
// Bytes with a low stop bit are dropped silently
//====================
`timescale 1ns/1ps

module uart_byte_rx (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rx,
	output rc_link_pkg::rc_byte_t rx_byte,
	output logic                  byte_valid
);

	import rc_link_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic      rx_meta;
	logic      rx_sync;
	bit_cnt_t  clk_cnt;
	logic [2:0] bit_idx;
	rc_byte_t  shift_reg;

	// Line idles high, so sync flops come out of reset high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// Falling edge, possible start bit
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// Confirm start at mid-bit, glitches go back to idle
					if (clk_cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					// Mid stop bit, strobe only if the line is high
					if (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						byte_valid <= rx_sync;
						state <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data path, sampled at bit centers
	always_ff @(posedge clk) begin
		if (state == RX_DATA && clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
		if (state == RX_STOP && clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1) && rx_sync) begin
			rx_byte <= shift_reg;
		end
	end

	// A byte takes many clocks, so strobes can never touch
	a_single_strobe: assert property (@(posedge clk) disable iff (reset)
		byte_valid |=> !byte_valid);

endmodule

// File: src/frame_decoder.sv
//====================
// Parses 16-byte frames: sync, 9 fields, FRAME_RESERVED_BYTES reserved
// A gap of GAP_TIMEOUT cycles drops a partial frame
// Field outputs may show partial data, only frame_valid marks a whole frame
//====================
`timescale 1ns/1ps

module frame_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  rc_link_pkg::rc_byte_t rx_byte,
	input  logic                  byte_valid,
	output logic                  frame_valid,
	output rc_link_pkg::rc_byte_t alt_cmd,
	output rc_link_pkg::rc_byte_t ch2,
	output rc_link_pkg::rc_byte_t ch3,
	output rc_link_pkg::rc_byte_t ch4,
	output rc_link_pkg::rc_byte_t alt_kp,
	output rc_link_pkg::rc_byte_t off2,
	output rc_link_pkg::rc_byte_t off3,
	output rc_link_pkg::rc_byte_t off4,
	output rc_link_pkg::rc_byte_t alt_ki
);

	import rc_link_pkg::*;

	typedef enum logic [3:0] {
		S_SYNC1,
		S_SYNC2,
		S_ALT,
		S_CH2,
		S_CH3,
		S_CH4,
		S_KP,
		S_OFF2,
		S_OFF3,
		S_OFF4,
		S_KI,
		S_RSV
	} dec_state_t;

	dec_state_t state;
	gap_cnt_t   gap_cnt;
	rsv_cnt_t   rsv_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_SYNC1;
			gap_cnt <= '0;
			rsv_cnt <= '0;
			frame_valid <= 1'b0;
			alt_cmd <= DEFAULT_ALT;
			ch2 <= DEFAULT_STICK;
			ch3 <= DEFAULT_STICK;
			ch4 <= DEFAULT_STICK;
			alt_kp <= DEFAULT_KP;
			off2 <= DEFAULT_OFFSET;
			off3 <= DEFAULT_OFFSET;
			off4 <= DEFAULT_OFFSET;
			alt_ki <= DEFAULT_KI;
		end else begin
			frame_valid <= 1'b0;
			if (byte_valid) begin
				gap_cnt <= '0;
				case (state)
					S_SYNC1: state <= (rx_byte == SYNC1) ? S_SYNC2 : S_SYNC1;
					// Any mismatch restarts the search, even a second 0xFF
					S_SYNC2: state <= (rx_byte == SYNC2) ? S_ALT : S_SYNC1;
					S_ALT: begin
						// Dead zone, too low to be a real altitude request
						alt_cmd <= (rx_byte < ALT_DEAD_ZONE) ? '0 : rx_byte;
						state <= S_CH2;
					end
					S_CH2: begin
						ch2 <= rx_byte;
						state <= S_CH3;
					end
					S_CH3: begin
						ch3 <= rx_byte;
						state <= S_CH4;
					end
					S_CH4: begin
						ch4 <= rx_byte;
						state <= S_KP;
					end
					S_KP: begin
						alt_kp <= rx_byte;
						state <= S_OFF2;
					end
					S_OFF2: begin
						off2 <= rx_byte;
						state <= S_OFF3;
					end
					S_OFF3: begin
						off3 <= rx_byte;
						state <= S_OFF4;
					end
					S_OFF4: begin
						off4 <= rx_byte;
						state <= S_KI;
					end
					S_KI: begin
						alt_ki <= rx_byte;
						state <= S_RSV;
					end
					S_RSV: begin
						// Reserved content is ignored, only counted
						if (rsv_cnt == rsv_cnt_t'(FRAME_RESERVED_BYTES - 1)) begin
							rsv_cnt <= '0;
							frame_valid <= 1'b1;
							state <= S_SYNC1;
						end else begin
							rsv_cnt <= rsv_cnt + 1'b1;
						end
					end
					default: state <= S_SYNC1;
				endcase
			end else if (state != S_SYNC1) begin
				// Inside a frame, watch for a stalled link
				if (gap_cnt == gap_cnt_t'(GAP_TIMEOUT - 1)) begin
					gap_cnt <= '0;
					rsv_cnt <= '0;
					state <= S_SYNC1;
				end else begin
					gap_cnt <= gap_cnt + 1'b1;
				end
			end else begin
				gap_cnt <= '0;
			end
		end
	end

	// Frame end only ever comes from the last reserved byte
	a_frame_end: assert property (@(posedge clk) disable iff (reset)
		frame_valid |-> $past(state == S_RSV && byte_valid) && state == S_SYNC1);

endmodule

// File: src/link_failsafe.sv
//====================
// Holds the last good frame, falls back to defaults after LINK_TIMEOUT
// Timer only runs once a link existed, so no failsafe pulse at start-up
//====================
`timescale 1ns/1ps

module link_failsafe (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  frame_valid,
	input  rc_link_pkg::rc_byte_t alt_cmd,
	input  rc_link_pkg::rc_byte_t ch2,
	input  rc_link_pkg::rc_byte_t ch3,
	input  rc_link_pkg::rc_byte_t ch4,
	input  rc_link_pkg::rc_byte_t alt_kp,
	input  rc_link_pkg::rc_byte_t off2,
	input  rc_link_pkg::rc_byte_t off3,
	input  rc_link_pkg::rc_byte_t off4,
	input  rc_link_pkg::rc_byte_t alt_ki,
	output logic                  cmd_valid,
	output logic                  link_ok,
	output rc_link_pkg::rc_byte_t alt_cmd_hold,
	output rc_link_pkg::rc_byte_t ch2_hold,
	output rc_link_pkg::rc_byte_t ch3_hold,
	output rc_link_pkg::rc_byte_t ch4_hold,
	output rc_link_pkg::rc_byte_t alt_kp_hold,
	output rc_link_pkg::rc_byte_t off2_hold,
	output rc_link_pkg::rc_byte_t off3_hold,
	output rc_link_pkg::rc_byte_t off4_hold,
	output rc_link_pkg::rc_byte_t alt_ki_hold
);

	import rc_link_pkg::*;

	link_cnt_t link_cnt;
	logic      link_lost;

	// Last idle cycle of a live link
	assign link_lost = link_ok && !frame_valid &&
		(link_cnt == link_cnt_t'(LINK_TIMEOUT - 1));

	always_ff @(posedge clk) begin
		if (reset || link_lost) begin
			alt_cmd_hold <= DEFAULT_ALT;
			ch2_hold <= DEFAULT_STICK;
			ch3_hold <= DEFAULT_STICK;
			ch4_hold <= DEFAULT_STICK;
			alt_kp_hold <= DEFAULT_KP;
			off2_hold <= DEFAULT_OFFSET;
			off3_hold <= DEFAULT_OFFSET;
			off4_hold <= DEFAULT_OFFSET;
			alt_ki_hold <= DEFAULT_KI;
		end else if (frame_valid) begin
			alt_cmd_hold <= alt_cmd;
			ch2_hold <= ch2;
			ch3_hold <= ch3;
			ch4_hold <= ch4;
			alt_kp_hold <= alt_kp;
			off2_hold <= off2;
			off3_hold <= off3;
			off4_hold <= off4;
			alt_ki_hold <= alt_ki;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			link_cnt <= '0;
			link_ok <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			// One update per frame and one on link loss
			cmd_valid <= frame_valid || link_lost;
			if (frame_valid) begin
				link_cnt <= '0;
				link_ok <= 1'b1;
			end else if (link_lost) begin
				link_cnt <= '0;
				link_ok <= 1'b0;
			end else if (link_ok) begin
				link_cnt <= link_cnt + 1'b1;
			end
		end
	end

	// A loss update must carry the safe values downstream
	a_loss_defaults: assert property (@(posedge clk) disable iff (reset)
		cmd_valid && !link_ok |->
			alt_cmd_hold == DEFAULT_ALT && ch2_hold == DEFAULT_STICK &&
			ch3_hold == DEFAULT_STICK && ch4_hold == DEFAULT_STICK &&
			alt_kp_hold == DEFAULT_KP && off2_hold == DEFAULT_OFFSET &&
			off3_hold == DEFAULT_OFFSET && off4_hold == DEFAULT_OFFSET &&
			alt_ki_hold == DEFAULT_KI);

endmodule

// File: src/setpoint_mixer.sv
//====================
// Stick plus trim around STICK_CENTER, clamped to signed 8 bits
// Outputs change only on cmd_valid
//====================
`timescale 1ns/1ps

module setpoint_mixer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmd_valid,
	input  rc_link_pkg::rc_byte_t  alt_cmd_hold,
	input  rc_link_pkg::rc_byte_t  ch2_hold,
	input  rc_link_pkg::rc_byte_t  ch3_hold,
	input  rc_link_pkg::rc_byte_t  ch4_hold,
	input  rc_link_pkg::rc_byte_t  alt_kp_hold,
	input  rc_link_pkg::rc_byte_t  off2_hold,
	input  rc_link_pkg::rc_byte_t  off3_hold,
	input  rc_link_pkg::rc_byte_t  off4_hold,
	input  rc_link_pkg::rc_byte_t  alt_ki_hold,
	output logic                   setpoint_valid,
	output rc_link_pkg::setpoint_t roll_sp,
	output rc_link_pkg::setpoint_t pitch_sp,
	output rc_link_pkg::setpoint_t yaw_sp,
	output rc_link_pkg::rc_byte_t  alt_cmd_out,
	output rc_link_pkg::rc_byte_t  kp_out,
	output rc_link_pkg::rc_byte_t  ki_out
);

	import rc_link_pkg::*;

	// One axis, sum range is -256 to 254
	function automatic setpoint_t mix_axis(input rc_byte_t stick, input rc_byte_t trim);
		mix_sum_t center;
		mix_sum_t sum;
		center = $signed({2'b00, STICK_CENTER});
		sum = $signed({2'b00, stick}) - center + $signed({2'b00, trim}) - center;
		if (sum > mix_sum_t'(SP_MAX)) begin
			return SP_MAX;
		end else if (sum < mix_sum_t'(SP_MIN)) begin
			return SP_MIN;
		end
		return sum[7:0];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			setpoint_valid <= 1'b0;
			roll_sp <= '0;
			pitch_sp <= '0;
			yaw_sp <= '0;
			alt_cmd_out <= DEFAULT_ALT;
			kp_out <= DEFAULT_KP;
			ki_out <= DEFAULT_KI;
		end else begin
			setpoint_valid <= cmd_valid;
			if (cmd_valid) begin
				roll_sp <= mix_axis(ch2_hold, off2_hold);
				pitch_sp <= mix_axis(ch3_hold, off3_hold);
				yaw_sp <= mix_axis(ch4_hold, off4_hold);
				// Altitude loop values go through untouched
				alt_cmd_out <= alt_cmd_hold;
				kp_out <= alt_kp_hold;
				ki_out <= alt_ki_hold;
			end
		end
	end

	// Upstream never sends back-to-back updates
	a_valid_follows: assert property (@(posedge clk) disable iff (reset)
		setpoint_valid |-> $past(cmd_valid) && !$past(setpoint_valid));

endmodule

// File: src/rc_link_top.sv
//====================
// RC receive chain, serial in to mixed setpoints
// Frame end to setpoint_valid is 3 cycles, link loss to it 2 cycles
//====================
`timescale 1ns/1ps

module rc_link_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rx,
	output logic                   setpoint_valid,
	output logic                   link_ok,
	output rc_link_pkg::setpoint_t roll_sp,
	output rc_link_pkg::setpoint_t pitch_sp,
	output rc_link_pkg::setpoint_t yaw_sp,
	output rc_link_pkg::rc_byte_t  alt_cmd_out,
	output rc_link_pkg::rc_byte_t  kp_out,
	output rc_link_pkg::rc_byte_t  ki_out
);

	import rc_link_pkg::*;

	// Receiver to decoder
	rc_byte_t rx_byte;
	logic     byte_valid;

	// Decoder to failsafe
	logic     frame_valid;
	rc_byte_t alt_cmd, ch2, ch3, ch4, alt_kp, off2, off3, off4, alt_ki;

	// Failsafe to mixer
	logic     cmd_valid;
	rc_byte_t alt_cmd_hold, ch2_hold, ch3_hold, ch4_hold, alt_kp_hold;
	rc_byte_t off2_hold, off3_hold, off4_hold, alt_ki_hold;

	uart_byte_rx rx0 (
		.clk(clk), .reset(reset), .rx(rx),
		.rx_byte(rx_byte), .byte_valid(byte_valid)
	);

	frame_decoder dec0 (
		.clk(clk), .reset(reset), .rx_byte(rx_byte), .byte_valid(byte_valid),
		.frame_valid(frame_valid), .alt_cmd(alt_cmd),
		.ch2(ch2), .ch3(ch3), .ch4(ch4), .alt_kp(alt_kp),
		.off2(off2), .off3(off3), .off4(off4), .alt_ki(alt_ki)
	);

	link_failsafe fs0 (
		.clk(clk), .reset(reset), .frame_valid(frame_valid), .alt_cmd(alt_cmd),
		.ch2(ch2), .ch3(ch3), .ch4(ch4), .alt_kp(alt_kp),
		.off2(off2), .off3(off3), .off4(off4), .alt_ki(alt_ki),
		.cmd_valid(cmd_valid), .link_ok(link_ok), .alt_cmd_hold(alt_cmd_hold),
		.ch2_hold(ch2_hold), .ch3_hold(ch3_hold), .ch4_hold(ch4_hold),
		.alt_kp_hold(alt_kp_hold), .off2_hold(off2_hold), .off3_hold(off3_hold),
		.off4_hold(off4_hold), .alt_ki_hold(alt_ki_hold)
	);

	setpoint_mixer mix0 (
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid),
		.alt_cmd_hold(alt_cmd_hold), .ch2_hold(ch2_hold), .ch3_hold(ch3_hold),
		.ch4_hold(ch4_hold), .alt_kp_hold(alt_kp_hold), .off2_hold(off2_hold),
		.off3_hold(off3_hold), .off4_hold(off4_hold), .alt_ki_hold(alt_ki_hold),
		.setpoint_valid(setpoint_valid), .roll_sp(roll_sp), .pitch_sp(pitch_sp),
		.yaw_sp(yaw_sp), .alt_cmd_out(alt_cmd_out), .kp_out(kp_out), .ki_out(ki_out)
	);

endmodule

// File: verification/rc_link_tb.sv
//====================
// Drives 8N1 frames into rc_link_top and checks every setpoint update
// Expected results queue in send order, one per setpoint_valid
// Run time is bounded by a cycle limit sized from the test lengths
//====================
`timescale 1ns/1ps

module rc_link_tb;

	import rc_link_pkg::*;

	// 46 full frames, 12 loose bytes, plus the two long silences
	localparam int NUM_FRAMES = 46;
	localparam int EXTRA_BYTES = 12;
	localparam int TEST_GAPS = GAP_TIMEOUT + LINK_TIMEOUT + 200 + NUM_FRAMES * 20;
	localparam int TIMEOUT_CYCLES = (NUM_FRAMES * 16 + EXTRA_BYTES) * 10 * CLKS_PER_BIT +
		TEST_GAPS + 2 * LINK_TIMEOUT + 2000;
	// Last stop bit to setpoint_valid is a few cycles, two byte times is plenty
	localparam int RESULT_WAIT = 2 * 10 * CLKS_PER_BIT;

	logic      clk;
	logic      reset;
	logic      rx;
	logic      setpoint_valid;
	logic      link_ok;
	setpoint_t roll_sp;
	setpoint_t pitch_sp;
	setpoint_t yaw_sp;
	rc_byte_t  alt_cmd_out;
	rc_byte_t  kp_out;
	rc_byte_t  ki_out;

	// Frame under construction, sync at 0 and 1
	rc_byte_t    fb [0:15];
	// Packed as roll, pitch, yaw, alt, kp, ki
	logic [47:0] exp_q [$];
	string       name_q [$];
	logic [47:0] exp_now;
	string       name_now;
	integer      seed = 75331;
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          sp_count = 0;
	int          cycle_count = 0;
	int          count_before;

	rc_link_top dut0 (
		.clk(clk), .reset(reset), .rx(rx),
		.setpoint_valid(setpoint_valid), .link_ok(link_ok),
		.roll_sp(roll_sp), .pitch_sp(pitch_sp), .yaw_sp(yaw_sp),
		.alt_cmd_out(alt_cmd_out), .kp_out(kp_out), .ki_out(ki_out)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// One axis: offsets from center added, then clamped to signed 8 bits
	function automatic logic [7:0] saturate_axis(input rc_byte_t stick, input rc_byte_t trim);
		int s;
		s = (int'(stick) - int'(STICK_CENTER)) + (int'(trim) - int'(STICK_CENTER));
		if (s > 127)
			s = 127;
		else if (s < -128)
			s = -128;
		return s[7:0];
	endfunction

	function automatic logic [47:0] expected_setpoints(input logic lost, input rc_byte_t alt,
		input rc_byte_t c2, input rc_byte_t c3, input rc_byte_t c4, input rc_byte_t kp,
		input rc_byte_t o2, input rc_byte_t o3, input rc_byte_t o4, input rc_byte_t ki);
		rc_byte_t alt_eff;
		// Link loss means the safe defaults
		if (lost)
			return {saturate_axis(DEFAULT_STICK, DEFAULT_OFFSET),
				saturate_axis(DEFAULT_STICK, DEFAULT_OFFSET),
				saturate_axis(DEFAULT_STICK, DEFAULT_OFFSET), DEFAULT_ALT, DEFAULT_KP, DEFAULT_KI};
		// Dead zone on altitude
		alt_eff = (alt < ALT_DEAD_ZONE) ? 8'd0 : alt;
		return {saturate_axis(c2, o2), saturate_axis(c3, o3), saturate_axis(c4, o4),
			alt_eff, kp, ki};
	endfunction

	task automatic check_field(input string test, input string field, input int expv,
		input int actv);
		assert (actv == expv) else begin
			value_errors++;
			$display("[FAIL] %s %s expected %0d actual %0d", test, field, expv, actv);
		end
	endtask

	// Start bit, 8 data bits LSB first, one stop bit
	task automatic send_byte(input rc_byte_t b);
		rx <= 1'b0;
		repeat (CLKS_PER_BIT) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			rx <= b[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
		end
		rx <= 1'b1;
		repeat (CLKS_PER_BIT) @(posedge clk);
	endtask

	task automatic idle_line(input int cycles);
		rx <= 1'b1;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic load_frame(input rc_byte_t alt, input rc_byte_t c2, input rc_byte_t c3,
		input rc_byte_t c4, input rc_byte_t kp, input rc_byte_t o2, input rc_byte_t o3,
		input rc_byte_t o4, input rc_byte_t ki);
		fb[0] = SYNC1;
		fb[1] = SYNC2;
		fb[2] = alt;
		fb[3] = c2;
		fb[4] = c3;
		fb[5] = c4;
		fb[6] = kp;
		fb[7] = o2;
		fb[8] = o3;
		fb[9] = o4;
		fb[10] = ki;
		// Reserved content should not matter
		for (int i = 11; i < 16; i++)
			fb[i] = $random(seed);
	endtask

	// Whole frame, expected result queued first
	task automatic send_frame(input string test);
		exp_q.push_back(expected_setpoints(1'b0, fb[2], fb[3], fb[4], fb[5], fb[6],
			fb[7], fb[8], fb[9], fb[10]));
		name_q.push_back(test);
		for (int i = 0; i < 16; i++)
			send_byte(fb[i]);
	endtask

	// Missing results are dropped so later frames stay aligned
	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < RESULT_WAIT) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			protocol_errors++;
			$display("%0d expected results never arrived", exp_q.size());
			exp_q.delete();
			name_q.delete();
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic check_count(input string test, input int want);
		assert (sp_count - count_before == want) else begin
			protocol_errors++;
			$display("%s: wanted %0d setpoint updates but saw %0d", test, want,
				sp_count - count_before);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d wrong values, %0d protocol errors", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	// Outputs are sampled mid-cycle, away from the clock edge
	always @(negedge clk) begin
		if (!reset && setpoint_valid) begin
			sp_count++;
			assert (exp_q.size() != 0) else begin
				protocol_errors++;
				$display("setpoint_valid arrived with no result expected");
			end
			if (exp_q.size() != 0) begin
				exp_now = exp_q.pop_front();
				name_now = name_q.pop_front();
				check_field(name_now, "roll", $signed(exp_now[47:40]), roll_sp);
				check_field(name_now, "pitch", $signed(exp_now[39:32]), pitch_sp);
				check_field(name_now, "yaw", $signed(exp_now[31:24]), yaw_sp);
				check_field(name_now, "alt", exp_now[23:16], alt_cmd_out);
				check_field(name_now, "kp", exp_now[15:8], kp_out);
				check_field(name_now, "ki", exp_now[7:0], ki_out);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			protocol_errors++;
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			finish_run();
		end
	end

	initial begin
		reset = 1'b1;
		rx = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		idle_line(20);
		assert (!link_ok && !setpoint_valid && roll_sp == 0 && pitch_sp == 0 &&
			yaw_sp == 0 && alt_cmd_out == DEFAULT_ALT && kp_out == DEFAULT_KP &&
			ki_out == DEFAULT_KI) else begin
			protocol_errors++;
			$display("Outputs after reset are not the idle defaults");
		end

		// Centered sticks and trims
		load_frame(8'd50, 8'd128, 8'd128, 8'd128, 8'd20, 8'd128, 8'd128, 8'd128, 8'd3);
		send_frame("nominal");
		wait_results();
		assert (link_ok) else begin
			protocol_errors++;
			$display("link_ok did not go high after a good frame");
		end

		// Saturation both ways, dead zone edge at 9 and 10
		load_frame(8'd9, 8'd255, 8'd0, 8'd255, 8'd7, 8'd255, 8'd0, 8'd0, 8'd1);
		send_frame("saturate low alt");
		load_frame(8'd10, 8'd200, 8'd10, 8'd0, 8'd8, 8'd200, 8'd60, 8'd255, 8'd2);
		send_frame("saturate alt 10");
		wait_results();

		// Garbage, wrong second sync, double 0xFF
		count_before = sp_count;
		send_byte(8'h12);
		send_byte(8'h5A);
		send_byte(8'hFF);
		send_byte(8'h33);
		send_byte(8'hFF);
		send_byte(8'hFF);
		load_frame(8'd77, 8'd140, 8'd100, 8'd128, 8'd30, 8'd120, 8'd128, 8'd160, 8'd4);
		send_frame("sync search");
		wait_results();
		check_count("sync search", 1);

		// Partial frame dropped by the gap timeout
		count_before = sp_count;
		load_frame(8'd90, 8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8);
		for (int i = 0; i < 6; i++)
			send_byte(fb[i]);
		idle_line(GAP_TIMEOUT + 50);
		load_frame(8'd60, 8'd130, 8'd126, 8'd129, 8'd12, 8'd128, 8'd131, 8'd127, 8'd5);
		send_frame("after gap");
		wait_results();
		check_count("after gap", 1);

		// Silence past LINK_TIMEOUT gives one default update
		count_before = sp_count;
		exp_q.push_back(expected_setpoints(1'b1, 0, 0, 0, 0, 0, 0, 0, 0, 0));
		name_q.push_back("link loss");
		idle_line(LINK_TIMEOUT + 100);
		check_count("link loss", 1);
		assert (!link_ok) else begin
			protocol_errors++;
			$display("link_ok still high after the link went silent");
		end
		load_frame(8'd40, 8'd150, 8'd110, 8'd128, 8'd18, 8'd128, 8'd128, 8'd100, 8'd6);
		send_frame("link back");
		wait_results();
		assert (link_ok) else begin
			protocol_errors++;
			$display("link_ok did not come back with a new frame");
		end

		// Back to back random frames
		for (int n = 0; n < 40; n++) begin
			load_frame($random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed), $random(seed), $random(seed), $random(seed), $random(seed));
			send_frame("random");
		end
		wait_results();

		finish_run();
	end

endmodule

// File: rc_link.f
src/rc_link_pkg.sv
src/uart_byte_rx.sv
src/frame_decoder.sv
src/link_failsafe.sv
src/setpoint_mixer.sv
src/rc_link_top.sv
verification/rc_link_tb.sv
